/* soc_pkg.sv */
package soc_pkg;

  typedef logic [15:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;
  typedef logic [2:0]  irq_code_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;

  // interrupt numbers seen by the host
  localparam irq_code_t IRQ_NONE   = 3'd0;
  localparam irq_code_t IRQ_TIMER0 = 3'd1;
  localparam irq_code_t IRQ_TIMER1 = 3'd2;

  // address map
  localparam addr_t RAM_BASE   = 16'h0000;
  localparam addr_t TIMER_BASE = 16'h1000;
  localparam int    TIMER_SPAN = 32;  // bytes

  // timer register offsets inside its window
  localparam logic [4:0] TMR_CTRL   = 5'h00;
  localparam logic [4:0] TMR_CMP0   = 5'h04;
  localparam logic [4:0] TMR_CMP1   = 5'h08;
  localparam logic [4:0] TMR_CNT0   = 5'h0c;
  localparam logic [4:0] TMR_CNT1   = 5'h10;
  localparam logic [4:0] TMR_STATUS = 5'h14;

  typedef enum logic [1:0] {TGT_NONE, TGT_RAM, TGT_TIMER} target_e;

  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } bus_req_t;

  typedef struct packed {
    logic  ack;
    data_t rdata;
  } bus_rsp_t;

endpackage

/* axil_slave_port.sv */
`timescale 1ns/1ps

module axil_slave_port import soc_pkg::*; (
  input  logic     sysclock,
  input  logic     rst_i,
  input  addr_t    s_awaddr_i,
  input  logic     s_awvalid_i,
  output logic     s_awready_o,
  input  data_t    s_wdata_i,
  input  strb_t    s_wstrb_i,
  input  logic     s_wvalid_i,
  output logic     s_wready_o,
  output resp_t    s_bresp_o,
  output logic     s_bvalid_o,
  input  logic     s_bready_i,
  input  addr_t    s_araddr_i,
  input  logic     s_arvalid_i,
  output logic     s_arready_o,
  output data_t    s_rdata_o,
  output resp_t    s_rresp_o,
  output logic     s_rvalid_o,
  input  logic     s_rready_i,
  output bus_req_t req_o,
  input  logic     ack_i,
  input  data_t    rdata_i,
  input  resp_t    resp_i
);

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT, RESP} state_e;

  state_e state;
  logic   wr_rdy;  // awready and wready together
  logic   rd_rdy;
  logic   wr_accept;
  logic   rd_accept;
  logic   is_write;
  logic   req_valid;
  addr_t  req_addr;
  data_t  req_wdata;
  strb_t  req_strb;
  logic   bvalid;
  logic   rvalid;
  data_t  rsp_data;
  resp_t  rsp_code;

  assign wr_accept = wr_rdy & s_awvalid_i & s_wvalid_i;
  assign rd_accept = rd_rdy & s_arvalid_i;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      state     <= IDLE;
      wr_rdy    <= 1'b0;
      rd_rdy    <= 1'b0;
      is_write  <= 1'b0;
      req_valid <= 1'b0;
      bvalid    <= 1'b0;
      rvalid    <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (wr_accept) begin
            wr_rdy   <= 1'b0;
            is_write <= 1'b1;
            state    <= ISSUE;
          end else if (rd_accept) begin
            rd_rdy   <= 1'b0;
            is_write <= 1'b0;
            state    <= ISSUE;
          end else if (!wr_rdy && !rd_rdy) begin
            if (s_awvalid_i && s_wvalid_i)
              wr_rdy <= 1'b1;
            else if (s_arvalid_i && !s_awvalid_i && !s_wvalid_i)
              rd_rdy <= 1'b1;  // writes win
          end
        end
        ISSUE: begin
          req_valid <= 1'b1;
          state     <= WAIT;
        end
        WAIT: begin
          req_valid <= 1'b0;  // single cycle pulse
          if (ack_i) begin
            bvalid <= is_write;
            rvalid <= ~is_write;
            state  <= RESP;
          end
        end
        RESP: begin
          if ((bvalid && s_bready_i) || (rvalid && s_rready_i)) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            state  <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge sysclock) begin
    if (wr_accept) begin
      req_addr  <= s_awaddr_i;
      req_wdata <= s_wdata_i;
      req_strb  <= s_wstrb_i;
    end else if (rd_accept) begin
      req_addr  <= s_araddr_i;
      req_wdata <= '0;
      req_strb  <= '0;
    end
    if (state == WAIT && ack_i) begin
      rsp_data <= is_write ? '0 : rdata_i;
      rsp_code <= resp_i;
    end
  end

  assign s_awready_o = wr_rdy;
  assign s_wready_o  = wr_rdy;
  assign s_arready_o = rd_rdy;
  assign s_bvalid_o  = bvalid;
  assign s_bresp_o   = rsp_code;
  assign s_rvalid_o  = rvalid;
  assign s_rresp_o   = rsp_code;
  assign s_rdata_o   = rsp_data;

  assign req_o = '{valid: req_valid, we: is_write, addr: req_addr,
                   wdata: req_wdata, strb: req_strb};

endmodule

/* addr_decoder.sv */
`timescale 1ns/1ps

module addr_decoder import soc_pkg::*; #(
  parameter int RAM_WORDS = 256
) (
  input  addr_t   addr_i,
  output target_e target_o,
  output logic    decerr_o
);

  localparam int RAM_BYTES = RAM_WORDS * 4;

  addr_t ram_off;
  addr_t tmr_off;

  // offsets wrap below the base, so one compare covers both ends
  assign ram_off = addr_i - RAM_BASE;
  assign tmr_off = addr_i - TIMER_BASE;

  always_comb begin
    target_o = TGT_NONE;
    decerr_o = 1'b0;
    if (int'(ram_off) < RAM_BYTES)
      target_o = TGT_RAM;
    else if (int'(tmr_off) < TIMER_SPAN)
      target_o = TGT_TIMER;
    else
      decerr_o = 1'b1;
  end

endmodule

/* scratch_ram.sv */
`timescale 1ns/1ps

module scratch_ram import soc_pkg::*; #(
  parameter int RAM_WORDS = 256
) (
  input  logic     sysclock,
  input  logic     rst_i,
  input  bus_req_t req_i,
  input  logic     sel_i,
  output bus_rsp_t rsp_o
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  data_t            mem [RAM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             access;
  logic             ack;
  data_t            rdata;

  assign idx    = req_i.addr[IDX_W+1:2];  // word index
  assign access = req_i.valid & sel_i;

  always_ff @(posedge sysclock) begin
    if (access) begin
      rdata <= mem[idx];
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.strb[b])
            mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i)
      ack <= 1'b0;
    else
      ack <= access;
  end

  assign rsp_o = '{ack: ack, rdata: rdata};

endmodule

/* timer_unit.sv */
`timescale 1ns/1ps

module timer_unit import soc_pkg::*; #(
  parameter int TIMER_WIDTH = 16
) (
  input  logic       sysclock,
  input  logic       rst_i,
  input  bus_req_t   req_i,
  input  logic       sel_i,
  output bus_rsp_t   rsp_o,
  output logic [1:0] pending_o,
  output logic       int_en_o
);

  typedef logic [TIMER_WIDTH-1:0] count_t;

  count_t     cnt [2];
  count_t     cmp [2];
  logic [1:0] tmr_en;
  logic [1:0] pending;
  logic [1:0] hit;    // compare match this cycle
  logic [1:0] clr;    // write-one-to-clear from STATUS
  logic       int_en;
  logic       access;
  logic       wr;
  logic [4:0] off;
  data_t      rd_word;
  logic       ack;
  data_t      rdata;

  assign access = req_i.valid & sel_i;
  assign wr     = access & req_i.we;
  assign off    = req_i.addr[4:0];
  assign clr    = (wr && off == TMR_STATUS) ? req_i.wdata[1:0] : 2'b00;

  always_comb begin
    for (int i = 0; i < 2; i++)
      hit[i] = tmr_en[i] && (cnt[i] == cmp[i]);
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      tmr_en  <= 2'b00;
      int_en  <= 1'b0;
      pending <= 2'b00;
      for (int i = 0; i < 2; i++) begin
        cnt[i] <= '0;
        cmp[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (tmr_en[i])
          cnt[i] <= hit[i] ? '0 : cnt[i] + count_t'(1);
      end
      pending <= (pending & ~clr) | hit;  // a new match wins over clear
      if (wr) begin
        case (off)
          TMR_CTRL: begin
            tmr_en <= req_i.wdata[1:0];
            int_en <= req_i.wdata[31];
          end
          TMR_CMP0: cmp[0] <= req_i.wdata[TIMER_WIDTH-1:0];
          TMR_CMP1: cmp[1] <= req_i.wdata[TIMER_WIDTH-1:0];
          default: ;  // counts and status handled above
        endcase
      end
    end
  end

  always_comb begin
    case (off)
      TMR_CTRL:   rd_word = {int_en, 29'd0, tmr_en};
      TMR_CMP0:   rd_word = data_t'(cmp[0]);
      TMR_CMP1:   rd_word = data_t'(cmp[1]);
      TMR_CNT0:   rd_word = data_t'(cnt[0]);
      TMR_CNT1:   rd_word = data_t'(cnt[1]);
      TMR_STATUS: rd_word = {30'd0, pending};
      default:    rd_word = '0;
    endcase
  end

  always_ff @(posedge sysclock) begin
    if (access)
      rdata <= rd_word;
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i)
      ack <= 1'b0;
    else
      ack <= access;
  end

  assign rsp_o     = '{ack: ack, rdata: rdata};
  assign pending_o = pending;
  assign int_en_o  = int_en;

endmodule

/* bus_combiner.sv */
`timescale 1ns/1ps

module bus_combiner import soc_pkg::*; (
  input  target_e    target_i,
  input  logic       decerr_i,
  input  logic       req_valid_i,
  input  bus_rsp_t   ram_rsp_i,
  input  bus_rsp_t   tmr_rsp_i,
  input  logic [1:0] pending_i,
  input  logic       int_en_i,
  output logic       ack_o,
  output data_t      rdata_o,
  output resp_t      resp_o,
  output irq_code_t  irq_o
);

  always_comb begin
    ack_o   = 1'b0;
    rdata_o = '0;
    resp_o  = RESP_OKAY;
    if (decerr_i) begin
      ack_o  = req_valid_i;  // nobody else will answer
      resp_o = RESP_DECERR;
    end else begin
      case (target_i)
        TGT_RAM: begin
          ack_o   = ram_rsp_i.ack;
          rdata_o = ram_rsp_i.rdata;
        end
        TGT_TIMER: begin
          ack_o   = tmr_rsp_i.ack;
          rdata_o = tmr_rsp_i.rdata;
        end
        default: ;
      endcase
    end
  end

  // timer 1 has the higher priority
  always_comb begin
    irq_o = IRQ_NONE;
    if (int_en_i) begin
      casez (pending_i)
        2'b1?:   irq_o = IRQ_TIMER1;
        2'b01:   irq_o = IRQ_TIMER0;
        default: irq_o = IRQ_NONE;
      endcase
    end
  end

endmodule

/* soc_fabric_top.sv */
`timescale 1ns/1ps

module soc_fabric_top import soc_pkg::*; #(
  parameter int RAM_WORDS   = 256,
  parameter int TIMER_WIDTH = 16
) (
  input  logic      sysclock,
  input  logic      rst_i,
  input  addr_t     s_awaddr_i,
  input  logic      s_awvalid_i,
  output logic      s_awready_o,
  input  data_t     s_wdata_i,
  input  strb_t     s_wstrb_i,
  input  logic      s_wvalid_i,
  output logic      s_wready_o,
  output resp_t     s_bresp_o,
  output logic      s_bvalid_o,
  input  logic      s_bready_i,
  input  addr_t     s_araddr_i,
  input  logic      s_arvalid_i,
  output logic      s_arready_o,
  output data_t     s_rdata_o,
  output resp_t     s_rresp_o,
  output logic      s_rvalid_o,
  input  logic      s_rready_i,
  output irq_code_t irq_o
);

  bus_req_t   req;
  target_e    target;
  logic       decerr;
  bus_rsp_t   ram_rsp;
  bus_rsp_t   tmr_rsp;
  logic [1:0] pending;
  logic       int_en;
  logic       ack;
  data_t      rdata;
  resp_t      resp;

  axil_slave_port port0 (
    .sysclock(sysclock), .rst_i(rst_i),
    .s_awaddr_i(s_awaddr_i), .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o),
    .s_wdata_i(s_wdata_i), .s_wstrb_i(s_wstrb_i), .s_wvalid_i(s_wvalid_i),
    .s_wready_o(s_wready_o),
    .s_bresp_o(s_bresp_o), .s_bvalid_o(s_bvalid_o), .s_bready_i(s_bready_i),
    .s_araddr_i(s_araddr_i), .s_arvalid_i(s_arvalid_i), .s_arready_o(s_arready_o),
    .s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o), .s_rvalid_o(s_rvalid_o),
    .s_rready_i(s_rready_i),
    .req_o(req), .ack_i(ack), .rdata_i(rdata), .resp_i(resp));

  addr_decoder #(.RAM_WORDS(RAM_WORDS)) dec0 (
    .addr_i(req.addr), .target_o(target), .decerr_o(decerr));

  scratch_ram #(.RAM_WORDS(RAM_WORDS)) ram0 (
    .sysclock(sysclock), .rst_i(rst_i), .req_i(req),
    .sel_i(target == TGT_RAM), .rsp_o(ram_rsp));

  timer_unit #(.TIMER_WIDTH(TIMER_WIDTH)) tmr0 (
    .sysclock(sysclock), .rst_i(rst_i), .req_i(req),
    .sel_i(target == TGT_TIMER), .rsp_o(tmr_rsp),
    .pending_o(pending), .int_en_o(int_en));

  bus_combiner comb0 (
    .target_i(target), .decerr_i(decerr), .req_valid_i(req.valid),
    .ram_rsp_i(ram_rsp), .tmr_rsp_i(tmr_rsp),
    .pending_i(pending), .int_en_i(int_en),
    .ack_o(ack), .rdata_o(rdata), .resp_o(resp), .irq_o(irq_o));

endmodule

/* soc_fabric_sva.sv */
`timescale 1ns/1ps

module soc_fabric_sva import soc_pkg::*; (
  input logic  sysclock,
  input logic  rst_i,
  input logic  awvalid_i,
  input logic  awready_i,
  input logic  wvalid_i,
  input logic  wready_i,
  input logic  arvalid_i,
  input logic  arready_i,
  input logic  bvalid_i,
  input logic  bready_i,
  input resp_t bresp_i,
  input logic  rvalid_i,
  input logic  rready_i,
  input data_t rdata_i,
  input resp_t rresp_i,
  input logic  req_valid_i
);

  logic wr_open;  // write accepted and B not taken yet
  logic rd_open;
  int   fail_count = 0;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      wr_open <= 1'b0;
      rd_open <= 1'b0;
    end else begin
      if (awvalid_i && awready_i)
        wr_open <= 1'b1;
      else if (bvalid_i && bready_i)
        wr_open <= 1'b0;
      if (arvalid_i && arready_i)
        rd_open <= 1'b1;
      else if (rvalid_i && rready_i)
        rd_open <= 1'b0;
    end
  end

  a_aw_hold: assert property (@(posedge sysclock) disable iff (rst_i)
    awvalid_i && wvalid_i && !awready_i |=> awvalid_i && wvalid_i)
    else begin
      $error("write address or data dropped before ready");
      fail_count++;
    end

  a_ar_hold: assert property (@(posedge sysclock) disable iff (rst_i)
    arvalid_i && !arready_i |=> arvalid_i)
    else begin
      $error("read address dropped before arready");
      fail_count++;
    end

  a_b_hold: assert property (@(posedge sysclock) disable iff (rst_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else begin
      $error("write response changed before bready");
      fail_count++;
    end

  a_r_hold: assert property (@(posedge sysclock) disable iff (rst_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else begin
      $error("read response changed before rready");
      fail_count++;
    end

  a_b_origin: assert property (@(posedge sysclock) disable iff (rst_i)
    bvalid_i |-> wr_open)
    else begin
      $error("write response without an accepted write");
      fail_count++;
    end

  a_r_origin: assert property (@(posedge sysclock) disable iff (rst_i)
    rvalid_i |-> rd_open)
    else begin
      $error("read response without an accepted read");
      fail_count++;
    end

  // outputs settle one edge into reset
  a_reset: assert property (@(posedge sysclock) rst_i && $past(rst_i) |->
    !(awready_i || wready_i || arready_i || bvalid_i || rvalid_i || req_valid_i))
    else begin
      $error("port outputs not zero in reset");
      fail_count++;
    end

endmodule

bind axil_slave_port soc_fabric_sva sva0 (
  .sysclock(sysclock), .rst_i(rst_i),
  .awvalid_i(s_awvalid_i), .awready_i(s_awready_o),
  .wvalid_i(s_wvalid_i), .wready_i(s_wready_o),
  .arvalid_i(s_arvalid_i), .arready_i(s_arready_o),
  .bvalid_i(s_bvalid_o), .bready_i(s_bready_i), .bresp_i(s_bresp_o),
  .rvalid_i(s_rvalid_o), .rready_i(s_rready_i), .rdata_i(s_rdata_o),
  .rresp_i(s_rresp_o), .req_valid_i(req_valid));

/* soc_fabric_checker.sv */
`timescale 1ns/1ps

module soc_fabric_checker import soc_pkg::*; #(
  parameter int NAME_W = 8*24
) (
  input logic      sysclock,
  input logic      rst_i,
  input logic      bvalid_i,
  input logic      bready_i,
  input resp_t     bresp_i,
  input logic      rvalid_i,
  input logic      rready_i,
  input data_t     rdata_i,
  input resp_t     rresp_i,
  input irq_code_t irq_i
);

  int checks = 0;
  int errors = 0;

  // expected responses, oldest first
  logic [NAME_W-1:0] name_q [$];
  logic              wr_q [$];
  data_t             data_q [$];
  data_t             mask_q [$];
  resp_t             resp_q [$];

  task automatic expect_rsp(input logic [NAME_W-1:0] name, input logic is_wr,
                            input data_t data, input data_t mask, input resp_t resp);
    name_q.push_back(name);
    wr_q.push_back(is_wr);
    data_q.push_back(data);
    mask_q.push_back(mask);
    resp_q.push_back(resp);
  endtask

  task automatic report_problem(input logic [NAME_W-1:0] name, input string msg);
    errors++;
    $display("%0s: %0s", name, msg);
  endtask

  task automatic check_irq(input logic [NAME_W-1:0] name, input irq_code_t exp);
    checks++;
    if (irq_i !== exp) begin
      errors++;
      $display("Fail %0s: expected %0d actual %0d", name, exp, irq_i);
    end
  endtask

  function automatic int outstanding();
    return data_q.size();
  endfunction

  task automatic compare_rsp(input logic is_wr, input data_t data, input resp_t resp);
    logic [NAME_W-1:0] name;
    logic              exp_wr;
    data_t             exp_data;
    data_t             mask;
    resp_t             exp_resp;
    if (data_q.size() == 0) begin
      report_problem("bus monitor", "response seen with no request outstanding");
      return;
    end
    name     = name_q.pop_front();
    exp_wr   = wr_q.pop_front();
    exp_data = data_q.pop_front();
    mask     = mask_q.pop_front();
    exp_resp = resp_q.pop_front();
    checks++;
    if (exp_wr != is_wr)
      report_problem(name, "response came back on the wrong channel");
    if (resp !== exp_resp) begin
      errors++;
      $display("Fail %0s: expected resp %0d actual resp %0d", name, exp_resp, resp);
    end
    if (!is_wr && ((data & mask) !== (exp_data & mask))) begin
      errors++;
      $display("Fail %0s: expected %h actual %h", name, exp_data, data);
    end
  endtask

  always @(posedge sysclock) begin
    if (!rst_i && bvalid_i && bready_i)
      compare_rsp(1'b1, '0, bresp_i);
    if (!rst_i && rvalid_i && rready_i)
      compare_rsp(1'b0, rdata_i, rresp_i);
  end

endmodule

/* tb_soc_fabric.sv */
`timescale 1ns/1ps

module tb_soc_fabric import soc_pkg::*; ();

  localparam int RAM_WORDS   = 256;
  localparam int TIMER_WIDTH = 16;
  localparam int NAME_W      = 8*24;
  localparam int MAX_ENTRIES = 40;

  typedef enum {OP_WRITE, OP_READ, OP_POLL, OP_IRQ} op_e;

  logic      sysclock = 1'b0;
  logic      rst_i;
  addr_t     s_awaddr_i;
  logic      s_awvalid_i;
  logic      s_awready_o;
  data_t     s_wdata_i;
  strb_t     s_wstrb_i;
  logic      s_wvalid_i;
  logic      s_wready_o;
  resp_t     s_bresp_o;
  logic      s_bvalid_o;
  logic      s_bready_i;
  addr_t     s_araddr_i;
  logic      s_arvalid_i;
  logic      s_arready_o;
  data_t     s_rdata_o;
  resp_t     s_rresp_o;
  logic      s_rvalid_o;
  logic      s_rready_i;
  irq_code_t irq_o;

  // one row per host operation
  logic [NAME_W-1:0] name_tab [MAX_ENTRIES];
  op_e               op_tab [MAX_ENTRIES];
  addr_t             addr_tab [MAX_ENTRIES];
  data_t             data_tab [MAX_ENTRIES];  // status mask for polls
  strb_t             strb_tab [MAX_ENTRIES];
  data_t             exp_tab [MAX_ENTRIES];   // expected code for irq rows
  resp_t             resp_tab [MAX_ENTRIES];
  int                bound_tab [MAX_ENTRIES];
  int                n_entries = 0;
  logic              table_ready = 1'b0;
  integer            seed = 9;
  logic [31:0]       stall;

  always #4 sysclock = ~sysclock;

  soc_fabric_top #(.RAM_WORDS(RAM_WORDS), .TIMER_WIDTH(TIMER_WIDTH)) soc_fabric_top_inst (.*);

  soc_fabric_checker #(.NAME_W(NAME_W)) checker_inst (
    .sysclock(sysclock), .rst_i(rst_i),
    .bvalid_i(s_bvalid_o), .bready_i(s_bready_i), .bresp_i(s_bresp_o),
    .rvalid_i(s_rvalid_o), .rready_i(s_rready_i), .rdata_i(s_rdata_o),
    .rresp_i(s_rresp_o), .irq_i(irq_o));

  // ready about three cycles in four
  always @(posedge sysclock) begin
    stall = $random(seed);
    s_bready_i <= stall[1:0] != 2'b00;
    s_rready_i <= stall[3:2] != 2'b00;
  end

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input strb_t strb);
    data_t lanes;
    lanes = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_w & ~lanes) | (new_w & lanes);
  endfunction

  task automatic add_entry(input logic [NAME_W-1:0] name, input op_e op, input addr_t addr,
                           input data_t data, input strb_t strb, input data_t exp,
                           input resp_t resp, input int bound);
    name_tab[n_entries]  = name;
    op_tab[n_entries]    = op;
    addr_tab[n_entries]  = addr;
    data_tab[n_entries]  = data;
    strb_tab[n_entries]  = strb;
    exp_tab[n_entries]   = exp;
    resp_tab[n_entries]  = resp;
    bound_tab[n_entries] = bound;
    n_entries++;
  endtask

  task automatic build_table();
    addr_t ram_top;
    addr_t ram_end;
    ram_top = addr_t'(RAM_WORDS * 4 - 4);
    ram_end = addr_t'(RAM_WORDS * 4);
    add_entry("irq after reset", OP_IRQ, '0, '0, '0, IRQ_NONE, RESP_OKAY, 0);
    add_entry("ram wr0", OP_WRITE, RAM_BASE, 32'hdeadbeef, 4'hf, '0, RESP_OKAY, 0);
    add_entry("ram rd0", OP_READ, RAM_BASE, '0, '0, 32'hdeadbeef, RESP_OKAY, 0);
    add_entry("ram wr1", OP_WRITE, 16'h0004, 32'h11223344, 4'hf, '0, RESP_OKAY, 0);
    add_entry("ram partial wr", OP_WRITE, 16'h0004, 32'haabbccdd, 4'b0101, '0, RESP_OKAY, 0);
    add_entry("ram partial rd", OP_READ, 16'h0004, '0, '0,
              merge_bytes(32'h11223344, 32'haabbccdd, 4'b0101), RESP_OKAY, 0);
    add_entry("ram top wr", OP_WRITE, ram_top, 32'h0badf00d, 4'hf, '0, RESP_OKAY, 0);
    add_entry("ram top rd", OP_READ, ram_top, '0, '0, 32'h0badf00d, RESP_OKAY, 0);
    add_entry("decerr wr", OP_WRITE, ram_end, 32'h12345678, 4'hf, '0, RESP_DECERR, 0);
    add_entry("decerr rd", OP_READ, ram_end, '0, '0, '0, RESP_DECERR, 0);
    add_entry("decerr rd past tmr", OP_READ, TIMER_BASE + 16'h20, '0, '0, '0, RESP_DECERR, 0);
    add_entry("decerr wr top", OP_WRITE, 16'hfffc, 32'h5a5a5a5a, 4'hf, '0, RESP_DECERR, 0);
    add_entry("tmr cmp0 wr", OP_WRITE, TIMER_BASE + TMR_CMP0, 32'd4, 4'hf, '0, RESP_OKAY, 0);
    add_entry("tmr cmp0 rd", OP_READ, TIMER_BASE + TMR_CMP0, '0, '0, 32'd4, RESP_OKAY, 0);
    add_entry("tmr cmp1 wr", OP_WRITE, TIMER_BASE + TMR_CMP1, 32'd6, 4'hf, '0, RESP_OKAY, 0);
    add_entry("tmr cmp1 rd", OP_READ, TIMER_BASE + TMR_CMP1, '0, '0, 32'd6, RESP_OKAY, 0);
    add_entry("tmr unused rd", OP_READ, TIMER_BASE + 16'h18, '0, '0, '0, RESP_OKAY, 0);
    add_entry("tmr unused rd2", OP_READ, TIMER_BASE + 16'h1c, '0, '0, '0, RESP_OKAY, 0);
    add_entry("tmr ctrl wr", OP_WRITE, TIMER_BASE + TMR_CTRL, 32'h80000001, 4'hf, '0, RESP_OKAY, 0);
    add_entry("tmr ctrl rd", OP_READ, TIMER_BASE + TMR_CTRL, '0, '0, 32'h80000001, RESP_OKAY, 0);
    add_entry("poll timer0", OP_POLL, TIMER_BASE + TMR_STATUS, 32'h1, '0, '0, RESP_OKAY, 10);
    add_entry("irq timer0", OP_IRQ, '0, '0, '0, IRQ_TIMER0, RESP_OKAY, 0);
    add_entry("tmr both wr", OP_WRITE, TIMER_BASE + TMR_CTRL, 32'h80000003, 4'hf, '0, RESP_OKAY, 0);
    add_entry("poll timer1", OP_POLL, TIMER_BASE + TMR_STATUS, 32'h2, '0, '0, RESP_OKAY, 10);
    add_entry("irq both", OP_IRQ, '0, '0, '0, IRQ_TIMER1, RESP_OKAY, 0);
    add_entry("int_en off wr", OP_WRITE, TIMER_BASE + TMR_CTRL, 32'h3, 4'hf, '0, RESP_OKAY, 0);
    add_entry("irq masked", OP_IRQ, '0, '0, '0, IRQ_NONE, RESP_OKAY, 0);
    add_entry("tmr stop wr", OP_WRITE, TIMER_BASE + TMR_CTRL, 32'h0, 4'hf, '0, RESP_OKAY, 0);
    add_entry("status clr wr", OP_WRITE, TIMER_BASE + TMR_STATUS, 32'h3, 4'hf, '0, RESP_OKAY, 0);
    add_entry("status rd", OP_READ, TIMER_BASE + TMR_STATUS, '0, '0, '0, RESP_OKAY, 0);
    add_entry("ram rd0 again", OP_READ, RAM_BASE, '0, '0, 32'hdeadbeef, RESP_OKAY, 0);
  endtask

  task automatic axil_write(input addr_t addr, input data_t data, input strb_t strb);
    @(posedge sysclock);
    s_awaddr_i  <= addr;
    s_wdata_i   <= data;
    s_wstrb_i   <= strb;
    s_awvalid_i <= 1'b1;
    s_wvalid_i  <= 1'b1;
    do @(posedge sysclock); while (!(s_awready_o && s_wready_o));
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    do @(posedge sysclock); while (!(s_bvalid_o && s_bready_i));
  endtask

  task automatic axil_read(input addr_t addr, output data_t data);
    @(posedge sysclock);
    s_araddr_i  <= addr;
    s_arvalid_i <= 1'b1;
    do @(posedge sysclock); while (!s_arready_o);
    s_arvalid_i <= 1'b0;
    do @(posedge sysclock); while (!(s_rvalid_o && s_rready_i));
    data = s_rdata_o;
  endtask

  task automatic run_poll(input int idx);
    data_t rd;
    int    tries;
    rd    = '0;
    tries = 0;
    while (((rd & data_tab[idx]) == 0) && tries < bound_tab[idx]) begin
      checker_inst.expect_rsp(name_tab[idx], 1'b0, '0, '0, resp_tab[idx]);
      axil_read(addr_tab[idx], rd);
      tries++;
    end
    if ((rd & data_tab[idx]) == 0)
      checker_inst.report_problem(name_tab[idx], "status bit never set within the poll bound");
  endtask

  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = n_entries * 40 + 8;  // reset and drain margin
    for (int i = 0; i < n_entries; i++) begin
      if (op_tab[i] == OP_POLL)
        limit += bound_tab[i] * 40;
    end
    repeat (limit) @(posedge sysclock);
    $display("watchdog: run hung, no end of test after %0d cycles", limit);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : stimulus
    data_t rd;
    rst_i       = 1'b1;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge sysclock);
    rst_i <= 1'b0;
    for (int i = 0; i < n_entries; i++) begin
      case (op_tab[i])
        OP_WRITE: begin
          checker_inst.expect_rsp(name_tab[i], 1'b1, '0, '0, resp_tab[i]);
          axil_write(addr_tab[i], data_tab[i], strb_tab[i]);
        end
        OP_READ: begin
          checker_inst.expect_rsp(name_tab[i], 1'b0, exp_tab[i], '1, resp_tab[i]);
          axil_read(addr_tab[i], rd);
        end
        OP_POLL: run_poll(i);
        default: begin
          @(posedge sysclock);
          checker_inst.check_irq(name_tab[i], irq_code_t'(exp_tab[i]));
        end
      endcase
    end
    repeat (4) @(posedge sysclock);
    if (checker_inst.outstanding() != 0)
      checker_inst.report_problem("end of run", "expected responses never arrived");
    $display("checks %0d, errors %0d, assertion failures %0d", checker_inst.checks,
             checker_inst.errors, soc_fabric_top_inst.port0.sva0.fail_count);
    if (checker_inst.errors == 0 && soc_fabric_top_inst.port0.sva0.fail_count == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* src.f */
soc_pkg.sv
axil_slave_port.sv
addr_decoder.sv
scratch_ram.sv
timer_unit.sv
bus_combiner.sv
soc_fabric_top.sv
soc_fabric_sva.sv
soc_fabric_checker.sv
tb_soc_fabric.sv
